// File: design/fetch_pkg.sv
package fetch_pkg;

    // ------------------------------------------------------------
    // Bus widths shared by the fetch unit and the memory
    // ------------------------------------------------------------

    // Byte address on the read-address channel and the PC
    typedef logic [31:0] addr_t;

    // One instruction word, also the memory data width
    typedef logic [31:0] word_t;

    // Read response code as on an AXI4 read-data channel
    typedef logic [1:0] resp_t;

    // ------------------------------------------------------------
    // Response codes
    // ------------------------------------------------------------

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

endpackage

// File: design/ifu.sv
`timescale 1ns/1ps

module ifu
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC = 32'h3000_0000
) (
    input  logic  clock,
    input  logic  reset,

    input  addr_t dnpc,
    input  logic  dnpc_valid,
    input  logic  pipe_stop,

    input  logic  inst_ready,
    output addr_t pc,
    output word_t inst,
    output logic  inst_valid,
    output logic  inst_fault,

    output logic  arvalid,
    output addr_t araddr,
    input  logic  arready,

    input  logic  rvalid,
    input  word_t rdata,
    input  resp_t rresp
);

    logic  consume;
    logic  redir_hold;
    logic  stop_hold;
    addr_t dnpc_hold;
    addr_t next_pc;

    assign consume = inst_valid && inst_ready;

    // The read address is always the current PC
    assign araddr = pc;

    // ------------------------------------------------------------
    // Instruction output stage
    // ------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            inst_valid <= 1'b0;
        end else if (rvalid) begin
            inst_valid <= 1'b1;
        end else if (consume) begin
            inst_valid <= 1'b0;
        end
    end

    // Word and fault flag only change when a response arrives
    always_ff @(posedge clock) begin
        if (rvalid) begin
            inst       <= rdata;
            inst_fault <= (rresp != RESP_OKAY);
        end
    end

    // ------------------------------------------------------------
    // Redirect and stall capture
    // ------------------------------------------------------------

    // Requests seen while decode holds off the pending word
    always_ff @(posedge clock) begin
        if (reset) begin
            redir_hold <= 1'b0;
            stop_hold  <= 1'b0;
        end else if (consume) begin
            redir_hold <= 1'b0;
            stop_hold  <= 1'b0;
        end else if (inst_valid) begin
            if (dnpc_valid) begin
                redir_hold <= 1'b1;
            end
            if (pipe_stop) begin
                stop_hold <= 1'b1;
            end
        end
    end

    // First redirect target wins until the consume
    always_ff @(posedge clock) begin
        if (inst_valid && !inst_ready && dnpc_valid && !redir_hold) begin
            dnpc_hold <= dnpc;
        end
    end

    // ------------------------------------------------------------
    // Next PC and read issue
    // ------------------------------------------------------------

    // Stall beats redirect, captured redirect beats live one
    always_comb begin
        if (pipe_stop || stop_hold) begin
            next_pc = pc;
        end else if (redir_hold) begin
            next_pc = dnpc_hold;
        end else if (dnpc_valid) begin
            next_pc = dnpc;
        end else begin
            next_pc = pc + 32'd4;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (consume) begin
            pc <= next_pc;
        end
    end

    // First fetch goes out right after reset
    always_ff @(posedge clock) begin
        if (reset) begin
            arvalid <= 1'b1;
        end else if (consume) begin
            arvalid <= 1'b1;
        end else if (arvalid && arready) begin
            arvalid <= 1'b0;
        end
    end

endmodule

// File: design/bank_dispatch.sv
`timescale 1ns/1ps

module bank_dispatch
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC   = 32'h3000_0000,
    parameter int    NUM_BANKS  = 4,
    parameter int    BANK_WORDS = 64,
    localparam int   ROW_BITS   = $clog2(BANK_WORDS)
) (
    input  logic                  clock,
    input  logic                  reset,

    input  logic                  arvalid,
    input  addr_t                 araddr,
    output logic                  arready,

    input  logic                  load_en,
    input  addr_t                 load_addr,
    input  word_t                 load_data,

    output logic [NUM_BANKS-1:0]  bank_req_valid,
    output logic [ROW_BITS-1:0]   bank_req_row,
    output logic [NUM_BANKS-1:0]  bank_ld_en,
    output logic [ROW_BITS-1:0]   ld_row,
    output word_t                 ld_data,

    output logic                  err_rvalid
);

    localparam int BANK_BITS    = $clog2(NUM_BANKS);
    localparam int WINDOW_WORDS = NUM_BANKS * BANK_WORDS;

    typedef logic [BANK_BITS-1:0] bank_idx_t;

    addr_t     rd_offset;
    addr_t     ld_offset;
    logic      rd_in_window;
    logic      ld_in_window;
    bank_idx_t rd_bank;
    bank_idx_t ld_bank;

    // Banks take a request every cycle
    assign arready = 1'b1;

    // ------------------------------------------------------------
    // Window, bank and row decode
    // ------------------------------------------------------------

    // Below the base wraps to a large offset and falls outside
    assign rd_offset    = araddr - RESET_PC;
    assign ld_offset    = load_addr - RESET_PC;
    assign rd_in_window = (rd_offset[31:2] < WINDOW_WORDS);
    assign ld_in_window = (ld_offset[31:2] < WINDOW_WORDS);

    // Word interleave: low word bits pick the bank
    assign rd_bank      = rd_offset[2 +: BANK_BITS];
    assign ld_bank      = ld_offset[2 +: BANK_BITS];
    assign bank_req_row = rd_offset[2 + BANK_BITS +: ROW_BITS];
    assign ld_row       = ld_offset[2 + BANK_BITS +: ROW_BITS];
    assign ld_data      = load_data;

    // ------------------------------------------------------------
    // Routing
    // ------------------------------------------------------------

    always_comb begin
        bank_req_valid = '0;
        bank_ld_en     = '0;
        if (arvalid && arready && rd_in_window) begin
            bank_req_valid[rd_bank] = 1'b1;
        end
        if (load_en && ld_in_window) begin
            bank_ld_en[ld_bank] = 1'b1;
        end
    end

    // Out-of-window reads answer one cycle later
    always_ff @(posedge clock) begin
        if (reset) begin
            err_rvalid <= 1'b0;
        end else begin
            err_rvalid <= arvalid && arready && !rd_in_window;
        end
    end

endmodule

// File: design/imem_bank.sv
`timescale 1ns/1ps

module imem_bank
    import fetch_pkg::*;
#(
    parameter int  BANK_WORDS = 64,
    localparam int ROW_BITS   = $clog2(BANK_WORDS)
) (
    input  logic                clock,
    input  logic                reset,

    input  logic                req_valid,
    input  logic [ROW_BITS-1:0] req_row,

    input  logic                ld_en,
    input  logic [ROW_BITS-1:0] ld_row,
    input  word_t               ld_data,

    output logic                rvalid,
    output word_t               rdata
);

    word_t mem [BANK_WORDS];

    logic  rd_valid_q;
    word_t rd_data_q;

    // Preload write port, also active during reset
    always_ff @(posedge clock) begin
        if (ld_en) begin
            mem[ld_row] <= ld_data;
        end
    end

    // ------------------------------------------------------------
    // Read pipeline: array read, then output register
    // ------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_valid_q <= 1'b0;
            rvalid     <= 1'b0;
        end else begin
            rd_valid_q <= req_valid;
            rvalid     <= rd_valid_q;
        end
    end

    always_ff @(posedge clock) begin
        rd_data_q <= mem[req_row];
        rdata     <= rd_data_q;
    end

endmodule

// File: design/read_merge.sv
`timescale 1ns/1ps

module read_merge
    import fetch_pkg::*;
#(
    parameter int NUM_BANKS = 4
) (
    input  logic                  clock,
    input  logic                  reset,

    input  logic [NUM_BANKS-1:0]  bank_rvalid,
    input  word_t [NUM_BANKS-1:0] bank_rdata,
    input  logic                  err_rvalid,

    output logic                  rvalid,
    output word_t                 rdata,
    output resp_t                 rresp
);

    logic  sel_valid;
    word_t sel_data;
    resp_t sel_resp;

    // ------------------------------------------------------------
    // Source select
    // ------------------------------------------------------------

    // Only one read is outstanding, so at most one source fires
    always_comb begin
        sel_valid = err_rvalid;
        sel_data  = '0;
        sel_resp  = RESP_OKAY;
        if (err_rvalid) begin
            sel_resp = RESP_SLVERR;
        end
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (bank_rvalid[i]) begin
                sel_valid = 1'b1;
                sel_data  = bank_rdata[i];
            end
        end
    end

    // ------------------------------------------------------------
    // Registered read-data channel
    // ------------------------------------------------------------

    always_ff @(posedge clock) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= sel_valid;
        end
    end

    always_ff @(posedge clock) begin
        rdata <= sel_data;
        rresp <= sel_resp;
    end

endmodule

// File: design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC   = 32'h3000_0000,
    parameter int    NUM_BANKS  = 4,
    parameter int    BANK_WORDS = 64
) (
    input  logic  clock,
    input  logic  reset,

    input  addr_t dnpc,
    input  logic  dnpc_valid,
    input  logic  pipe_stop,

    input  logic  inst_ready,
    output logic  inst_valid,
    output addr_t pc,
    output word_t inst,
    output logic  inst_fault,

    input  logic  load_en,
    input  addr_t load_addr,
    input  word_t load_data
);

    localparam int ROW_BITS = $clog2(BANK_WORDS);

    // Read-address and read-data channels
    logic                  arvalid;
    addr_t                 araddr;
    logic                  arready;
    logic                  rvalid;
    word_t                 rdata;
    resp_t                 rresp;

    // Dispatcher to banks and merge
    logic [NUM_BANKS-1:0]  bank_req_valid;
    logic [ROW_BITS-1:0]   bank_req_row;
    logic [NUM_BANKS-1:0]  bank_ld_en;
    logic [ROW_BITS-1:0]   ld_row;
    word_t                 ld_data;
    logic                  err_rvalid;
    logic [NUM_BANKS-1:0]  bank_rvalid;
    word_t [NUM_BANKS-1:0] bank_rdata;

    ifu #(
        .RESET_PC (RESET_PC)
    ) u_ifu (
        .clock      (clock),
        .reset      (reset),
        .dnpc       (dnpc),
        .dnpc_valid (dnpc_valid),
        .pipe_stop  (pipe_stop),
        .inst_ready (inst_ready),
        .pc         (pc),
        .inst       (inst),
        .inst_valid (inst_valid),
        .inst_fault (inst_fault),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .rresp      (rresp)
    );

    bank_dispatch #(
        .RESET_PC   (RESET_PC),
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) u_dispatch (
        .clock          (clock),
        .reset          (reset),
        .arvalid        (arvalid),
        .araddr         (araddr),
        .arready        (arready),
        .load_en        (load_en),
        .load_addr      (load_addr),
        .load_data      (load_data),
        .bank_req_valid (bank_req_valid),
        .bank_req_row   (bank_req_row),
        .bank_ld_en     (bank_ld_en),
        .ld_row         (ld_row),
        .ld_data        (ld_data),
        .err_rvalid     (err_rvalid)
    );

    // ------------------------------------------------------------
    // Interleaved banks
    // ------------------------------------------------------------

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        imem_bank #(
            .BANK_WORDS (BANK_WORDS)
        ) u_bank (
            .clock     (clock),
            .reset     (reset),
            .req_valid (bank_req_valid[i]),
            .req_row   (bank_req_row),
            .ld_en     (bank_ld_en[i]),
            .ld_row    (ld_row),
            .ld_data   (ld_data),
            .rvalid    (bank_rvalid[i]),
            .rdata     (bank_rdata[i])
        );
    end

    read_merge #(
        .NUM_BANKS (NUM_BANKS)
    ) u_merge (
        .clock       (clock),
        .reset       (reset),
        .bank_rvalid (bank_rvalid),
        .bank_rdata  (bank_rdata),
        .err_rvalid  (err_rvalid),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .rresp       (rresp)
    );

endmodule

// File: verification/fetch_asserts.sv
`timescale 1ns/1ps

module fetch_asserts
    import fetch_pkg::*;
(
    input logic  clock,
    input logic  reset,
    input logic  arvalid,
    input addr_t araddr,
    input logic  inst_valid,
    input logic  inst_ready,
    input addr_t pc,
    input word_t inst,
    input logic  inst_fault
);

    int fail_count = 0;

    // Read address is frozen from issue until the word is consumed
    ar_hold: assert property (@(posedge clock) disable iff (reset)
        !(inst_valid && inst_ready) |=> $stable(araddr))
    else begin
        $error("araddr changed while no instruction was consumed");
        fail_count++;
    end

    // Decode side holds still under back-pressure
    inst_hold: assert property (@(posedge clock) disable iff (reset)
        inst_valid && !inst_ready |=>
            inst_valid && $stable(inst) && $stable(pc) && $stable(inst_fault))
    else begin
        $error("instruction output moved while inst_ready was low");
        fail_count++;
    end

    // One fetch at a time
    no_overlap: assert property (@(posedge clock) disable iff (reset)
        !(arvalid && inst_valid))
    else begin
        $error("arvalid and inst_valid high together");
        fail_count++;
    end

endmodule

bind ifu fetch_asserts u_asserts (
    .clock      (clock),
    .reset      (reset),
    .arvalid    (arvalid),
    .araddr     (araddr),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .pc         (pc),
    .inst       (inst),
    .inst_fault (inst_fault)
);

// File: verification/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker
    import fetch_pkg::*;
#(
    parameter addr_t RESET_PC   = 32'h3000_0000,
    parameter int    NUM_BANKS  = 4,
    parameter int    BANK_WORDS = 64
) (
    input  logic  clock,
    input  logic  reset,
    input  logic  inst_valid,
    input  logic  inst_ready,
    input  addr_t pc,
    input  word_t inst,
    input  logic  inst_fault,
    input  addr_t dnpc,
    input  logic  dnpc_valid,
    input  logic  pipe_stop,
    input  logic  load_en,
    input  addr_t load_addr,
    input  word_t load_data
);

    localparam int WINDOW_WORDS = NUM_BANKS * BANK_WORDS;
    localparam int IDX_BITS     = $clog2(WINDOW_WORDS);

    // Memory contents as written through the preload port
    word_t model [WINDOW_WORDS];

    addr_t exp_pc;
    addr_t held_target;
    logic  held_redirect;
    logic  held_stop;

    // Snapshot of the outputs while decode holds off
    logic  pending;
    addr_t pend_pc;
    word_t pend_inst;
    logic  pend_fault;

    int consume_count = 0;
    int error_count   = 0;
    int fault_count   = 0;

    function automatic logic in_window(input addr_t addr);
        return (addr >= RESET_PC) && (addr < RESET_PC + 4 * WINDOW_WORDS);
    endfunction

    function automatic logic [IDX_BITS-1:0] word_index(input addr_t addr);
        addr_t offset;
        offset = addr - RESET_PC;
        return offset[IDX_BITS+1:2];
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // ------------------------------------------------------------
    // Sampling at the falling edge, where everything is settled
    // ------------------------------------------------------------

    always @(negedge clock) begin
        if (load_en && in_window(load_addr)) begin
            model[word_index(load_addr)] = load_data;
        end
        if (reset) begin
            exp_pc        = RESET_PC;
            held_redirect = 1'b0;
            held_stop     = 1'b0;
            pending       = 1'b0;
        end else if (inst_valid) begin
            if (pending) begin
                check_field("pc (held)", pc, pend_pc);
                check_field("inst (held)", inst, pend_inst);
                check_field("inst_fault (held)", {31'd0, inst_fault}, {31'd0, pend_fault});
            end else begin
                pending    = 1'b1;
                pend_pc    = pc;
                pend_inst  = inst;
                pend_fault = inst_fault;
            end
            if (inst_ready) begin
                consume_count++;
                check_field("pc", pc, exp_pc);
                if (in_window(exp_pc)) begin
                    check_field("inst", inst, model[word_index(exp_pc)]);
                    check_field("inst_fault", {31'd0, inst_fault}, 32'd0);
                end else begin
                    check_field("inst", inst, 32'd0);
                    check_field("inst_fault", {31'd0, inst_fault}, 32'd1);
                end
                if (inst_fault) begin
                    fault_count++;
                end
                // Stall keeps the PC, a held redirect beats a live one
                if (!(pipe_stop || held_stop)) begin
                    if (held_redirect) begin
                        exp_pc = held_target;
                    end else if (dnpc_valid) begin
                        exp_pc = dnpc;
                    end else begin
                        exp_pc = exp_pc + 32'd4;
                    end
                end
                held_redirect = 1'b0;
                held_stop     = 1'b0;
                pending       = 1'b0;
            end else begin
                if (dnpc_valid && !held_redirect) begin
                    held_redirect = 1'b1;
                    held_target   = dnpc;
                end
                if (pipe_stop) begin
                    held_stop = 1'b1;
                end
            end
        end
    end

endmodule

// File: verification/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb
    import fetch_pkg::*;
();

    localparam addr_t RESET_PC     = 32'h3000_0000;
    localparam int    NUM_BANKS    = 4;
    localparam int    BANK_WORDS   = 64;
    localparam int    WINDOW_WORDS = NUM_BANKS * BANK_WORDS;
    localparam int    RESET_CYCLES = 10;

    // Stimulus modes
    localparam int M_SEQ      = 0;
    localparam int M_REDIRECT = 1;
    localparam int M_STALL    = 2;
    localparam int M_PRESSURE = 3;
    localparam int M_LEAVE    = 4;
    localparam int M_RETURN   = 5;

    localparam int TOTAL_CONSUMES = 1 + 40 + 40 + 30 + 30 + 10;
    localparam int TIMEOUT_CYCLES = TOTAL_CONSUMES * 20 + WINDOW_WORDS;

    logic  clock;
    logic  reset;
    addr_t dnpc;
    logic  dnpc_valid;
    logic  pipe_stop;
    logic  inst_ready;
    logic  inst_valid;
    addr_t pc;
    word_t inst;
    logic  inst_fault;
    logic  load_en;
    addr_t load_addr;
    word_t load_data;

    int tb_errors = 0;
    int base_errors;
    int base_consumes;
    int base_faults;

    fetch_top #(
        .RESET_PC   (RESET_PC),
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) uut (
        .clock      (clock),
        .reset      (reset),
        .dnpc       (dnpc),
        .dnpc_valid (dnpc_valid),
        .pipe_stop  (pipe_stop),
        .inst_ready (inst_ready),
        .inst_valid (inst_valid),
        .pc         (pc),
        .inst       (inst),
        .inst_fault (inst_fault),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

    fetch_checker #(
        .RESET_PC   (RESET_PC),
        .NUM_BANKS  (NUM_BANKS),
        .BANK_WORDS (BANK_WORDS)
    ) u_check (
        .clock      (clock),
        .reset      (reset),
        .inst_valid (inst_valid),
        .inst_ready (inst_ready),
        .pc         (pc),
        .inst       (inst),
        .inst_fault (inst_fault),
        .dnpc       (dnpc),
        .dnpc_valid (dnpc_valid),
        .pipe_stop  (pipe_stop),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic int total_errors();
        return u_check.error_count + tb_errors + uut.u_ifu.u_asserts.fail_count;
    endfunction

    // Targets in the lower half keep later sequential runs inside the window
    function automatic addr_t window_target();
        return RESET_PC + (($urandom % (WINDOW_WORDS / 2)) << 2);
    endfunction

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------

    // Fill the whole window, reset drops partway through
    task automatic preload_memory();
        for (int i = 0; i < WINDOW_WORDS; i++) begin
            @(posedge clock);
            #1;
            if (i == RESET_CYCLES - 1) begin
                reset = 1'b0;
            end
            load_en   = 1'b1;
            load_addr = RESET_PC + 4 * i;
            load_data = $urandom;
        end
        @(posedge clock);
        #1;
        load_en = 1'b0;
    endtask

    task automatic drive_inputs(input int mode);
        case (mode)
            M_REDIRECT, M_STALL: inst_ready = ($urandom % 3 != 0);
            M_PRESSURE:          inst_ready = ($urandom % 4 == 0);
            default:             inst_ready = 1'b1;
        endcase
        dnpc       = $urandom & 32'hFFFF_FFFC;
        dnpc_valid = 1'b0;
        pipe_stop  = 1'b0;
        if (inst_valid) begin
            case (mode)
                M_REDIRECT: begin
                    if ($urandom % 4 == 0) begin
                        dnpc_valid = 1'b1;
                        dnpc       = window_target();
                    end
                end
                M_STALL:  pipe_stop = ($urandom % 4 == 0);
                M_LEAVE: begin
                    dnpc_valid = 1'b1;
                    dnpc       = RESET_PC + 4 * WINDOW_WORDS + (($urandom % 16) << 2);
                end
                M_RETURN: begin
                    dnpc_valid = 1'b1;
                    dnpc       = window_target();
                end
                default: ;
            endcase
        end
    endtask

    task automatic run_phase(input int mode, input int consumes);
        int done;
        done = 0;
        while (done < consumes) begin
            @(posedge clock);
            #1;
            drive_inputs(mode);
            if (inst_valid && inst_ready) begin
                done++;
            end
        end
        // Requests stay up through the edge of the last consume
        @(posedge clock);
        #1;
        dnpc_valid = 1'b0;
        pipe_stop  = 1'b0;
    endtask

    task automatic start_test();
        base_errors   = total_errors();
        base_consumes = u_check.consume_count;
        base_faults   = u_check.fault_count;
    endtask

    task automatic finish_test(input string name);
        $display("test %s: %0d consumes, %0d errors", name,
                 u_check.consume_count - base_consumes, total_errors() - base_errors);
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------

    initial begin
        void'($urandom(25));
        reset      = 1'b1;
        dnpc       = '0;
        dnpc_valid = 1'b0;
        pipe_stop  = 1'b0;
        inst_ready = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        preload_memory();

        start_test();
        run_phase(M_SEQ, 1);
        finish_test("first_fetch");

        start_test();
        run_phase(M_SEQ, 40);
        finish_test("sequential");

        start_test();
        run_phase(M_REDIRECT, 40);
        finish_test("redirect");

        start_test();
        run_phase(M_STALL, 30);
        finish_test("stall");

        start_test();
        run_phase(M_PRESSURE, 30);
        finish_test("back_pressure");

        start_test();
        run_phase(M_LEAVE, 1);
        run_phase(M_RETURN, 1);
        run_phase(M_SEQ, 8);
        if (u_check.fault_count == base_faults) begin
            $display("no faulting fetch was consumed after the out-of-window redirect");
            tb_errors++;
        end
        finish_test("window_fault");

        $display("summary: %0d consumes, %0d errors", u_check.consume_count, total_errors());
        if (total_errors() == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        $display("watchdog expired after %0d cycles, fetch stopped making progress",
                 TIMEOUT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: verilog.f
design/fetch_pkg.sv
design/ifu.sv
design/bank_dispatch.sv
design/imem_bank.sv
design/read_merge.sv
design/fetch_top.sv
verification/fetch_asserts.sv
verification/fetch_checker.sv
verification/fetch_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the fetch testbench"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		-f verilog.f --top-module fetch_tb --Mdir obj_dir -o fetch_sim
	./obj_dir/fetch_sim 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
